// File: files.f
+incdir+rtl
rtl/cpuIsaPkg.sv
rtl/cpuPipePkg.sv
rtl/fetchStage.sv
rtl/instructionDecoder.sv
rtl/registerFile.sv
rtl/operandBypass.sv
rtl/alu.sv
rtl/cpu.sv
tests/cpuChecker.sv
tests/cpuTb.sv

// File: Bender.yml
package:
  name: cpu16

export_include_dirs:
  - rtl

sources:
  - rtl/cpuIsaPkg.sv
  - rtl/cpuPipePkg.sv
  - rtl/fetchStage.sv
  - rtl/instructionDecoder.sv
  - rtl/registerFile.sv
  - rtl/operandBypass.sv
  - rtl/alu.sv
  - rtl/cpu.sv
  - target: test
    files:
      - tests/cpuChecker.sv
      - tests/cpuTb.sv

// File: tests/cpuTb.sv
`default_nettype none
`include "cpu_settings.svh"

module cpuTb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int memWords = 256;
  localparam int runLimit = 2000; // Cycles before the run is abandoned

  logic                                  clk;
  logic                                  rst;
  cpuIsaPkg::word_t                      Baddr;
  cpuIsaPkg::word_t                      Aaddr;
  cpuIsaPkg::word_t                      dataWrite;
  cpuIsaPkg::word_t                      BmemRead;
  cpuIsaPkg::word_t                      AmemRead;
  cpuIsaPkg::memControl_t                MeMemControl;
  cpuPipePkg::writeback_t                wb;
  cpuIsaPkg::word_t [`CPU_REG_COUNT-1:0] registerValue;

  cpuIsaPkg::word_t                progMem [memWords];
  cpuIsaPkg::word_t [memWords-1:0] dataMem;
  logic [31:0]                     randomState;

  logic             storePending;
  logic [7:0]       storeAddr;
  cpuIsaPkg::word_t storeData;

  int   valueErrors;
  int   protocolErrors;
  logic checkDone;
  logic checkStalled;
  int   guard;

  // LCG, upper half is the better distributed part
  function automatic cpuIsaPkg::word_t drawWord();
    randomState = randomState * 32'd1664525 + 32'd1013904223;
    return randomState[31:16];
  endfunction

  // Moves rs and rm off the register a load is still filling
  function automatic cpuIsaPkg::word_t avoidLoadTarget(input cpuIsaPkg::word_t instr,
                                                       input cpuIsaPkg::regIndex_t target);
    cpuIsaPkg::word_t fixed;
    fixed = instr;
    if (fixed[7:4] == target) fixed[7:4] = target + 4'd1;
    if (fixed[3:0] == target) fixed[3:0] = target + 4'd1;
    return fixed;
  endfunction

  task automatic loadMemories();
    logic                 loadBefore;
    cpuIsaPkg::regIndex_t target;
    cpuIsaPkg::word_t     instr;
    randomState = 32'h3573_aead;
    loadBefore  = 1'b0;
    target      = '0;
    for (int i = 0; i < memWords; i++) begin
      instr = drawWord();
      if (loadBefore) instr = avoidLoadTarget(instr, target);
      progMem[i] = instr;
      loadBefore = (instr[15:12] == cpuIsaPkg::LD);
      target     = instr[11:8];
    end
    for (int i = 0; i < memWords; i++) begin
      dataMem[i] = drawWord();
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  cpu cpu_inst (
    .clk          (clk),
    .rst          (rst),
    .Baddr        (Baddr),
    .Aaddr        (Aaddr),
    .dataWrite    (dataWrite),
    .MeMemControl (MeMemControl),
    .BmemRead     (BmemRead),
    .AmemRead     (AmemRead),
    .wb           (wb),
    .registerValue(registerValue)
  );

  cpuChecker modelCheck (
    .clk           (clk),
    .rst           (rst),
    .Baddr         (Baddr),
    .BmemRead      (BmemRead),
    .Aaddr         (Aaddr),
    .dataWrite     (dataWrite),
    .MeMemControl  (MeMemControl),
    .wb            (wb),
    .registerValue (registerValue),
    .dataImage     (dataMem),
    .valueErrors   (valueErrors),
    .protocolErrors(protocolErrors),
    .done          (checkDone),
    .stalled       (checkStalled)
  );

  // Store request is stable mid-cycle
  always @(negedge clk) begin
    storePending = (rst === 1'b0) && (MeMemControl == cpuIsaPkg::MEM_WRITE);
    storeAddr    = Aaddr[7:0];
    storeData    = dataWrite;
  end

  // Memory answers once per cycle, shortly after the DUT outputs settle
  always @(posedge clk) begin
    #2;
    if (storePending) dataMem[storeAddr] = storeData;
    storePending = 1'b0;
    BmemRead = progMem[Baddr[7:0]];
    AmemRead = dataMem[Aaddr[7:0]];
  end

  initial begin
    rst          = 1'b1;
    BmemRead     = '0;
    AmemRead     = '0;
    storePending = 1'b0;
    loadMemories();
    repeat (8) @(posedge clk);
    #2 rst = 1'b0;

    guard = 0;
    while (!checkDone && !checkStalled && guard < runLimit) begin
      @(posedge clk);
      guard++;
    end
    if (!checkDone && !checkStalled) begin
      $display("Checker did not finish within %0d cycles", runLimit);
    end

    $display("Run ended with %0d value errors and %0d protocol errors",
             valueErrors, protocolErrors);
    if (checkDone && valueErrors == 0 && protocolErrors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/cpuChecker.sv
`default_nettype none
`include "cpu_settings.svh"

module cpuChecker (
  input  logic                                  clk,
  input  logic                                  rst,
  input  cpuIsaPkg::word_t                      Baddr,
  input  cpuIsaPkg::word_t                      BmemRead,
  input  cpuIsaPkg::word_t                      Aaddr,
  input  cpuIsaPkg::word_t                      dataWrite,
  input  cpuIsaPkg::memControl_t                MeMemControl,
  input  cpuPipePkg::writeback_t                wb,
  input  cpuIsaPkg::word_t [`CPU_REG_COUNT-1:0] registerValue,
  input  cpuIsaPkg::word_t [255:0]              dataImage,
  output int                                    valueErrors,
  output int                                    protocolErrors,
  output logic                                  done,
  output logic                                  stalled
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int runLength  = 240;
  localparam int idleLimit  = 40;  // Cycles without any writeback
  localparam int resetLimit = 64;
  localparam int pipeDepth  = 3;   // Fetch address to writeback

  cpuIsaPkg::word_t         modelRegs [`CPU_REG_COUNT];
  cpuIsaPkg::word_t [255:0] memCopy;
  cpuIsaPkg::word_t         fetched [$];  // Program order, oldest first
  int cycle;
  int retired;
  int idle;
  int waitCycles;

  task automatic checkField(input string name, input logic [15:0] got,
                            input logic [15:0] expected, input bit isValue);
    if (got !== expected) begin
      $display("ERROR at %0d ns: %s is %h, expected %h", $time, name, got, expected);
      if (isValue) valueErrors++;
      else protocolErrors++;
    end
  endtask

  // One architectural step, compared with what the memory stage shows
  task automatic retireInstruction(input cpuIsaPkg::word_t instr);
    logic [3:0]             op;
    cpuIsaPkg::regIndex_t   rt;
    cpuIsaPkg::regIndex_t   rs;
    cpuIsaPkg::regIndex_t   rm;
    cpuIsaPkg::word_t       opS;
    cpuIsaPkg::word_t       opM;
    cpuIsaPkg::word_t       expected;
    logic                   writes;
    cpuIsaPkg::memControl_t access;
    op       = instr[15:12];
    rt       = instr[11:8];
    rs       = instr[7:4];
    rm       = instr[3:0];
    opS      = modelRegs[rs];
    opM      = modelRegs[rm];
    writes   = 1'b1;
    access   = cpuIsaPkg::MEM_NONE;
    expected = '0;
    case (op)
      cpuIsaPkg::ADD: expected = opS + opM;
      cpuIsaPkg::SUB: expected = opS - opM;
      cpuIsaPkg::AND: expected = opS & opM;
      cpuIsaPkg::OR:  expected = opS | opM;
      cpuIsaPkg::XOR: expected = opS ^ opM;
      cpuIsaPkg::SHL: expected = opS << opM[3:0];
      cpuIsaPkg::SHR: expected = opS >> opM[3:0];
      cpuIsaPkg::LDI: expected = {{8{instr[7]}}, instr[7:0]};
      cpuIsaPkg::LD: begin
        access   = cpuIsaPkg::MEM_READ;
        expected = memCopy[opS[7:0]];
      end
      cpuIsaPkg::ST: begin
        access = cpuIsaPkg::MEM_WRITE;
        writes = 1'b0;
      end
      default: writes = 1'b0; // NOP and undefined codes
    endcase

    checkField("wb.valid", wb.valid, writes, 1'b0);
    checkField("MeMemControl", MeMemControl, access, 1'b0);
    if (writes) begin
      checkField("wb.rt", wb.rt, rt, 1'b0);
      checkField("wb.value", wb.value, expected, 1'b1);
      modelRegs[rt] = expected;
    end
    if (access != cpuIsaPkg::MEM_NONE) checkField("Aaddr", Aaddr, opS, 1'b1);
    if (access == cpuIsaPkg::MEM_WRITE) begin
      checkField("dataWrite", dataWrite, opM, 1'b1);
      memCopy[opS[7:0]] = opM;
    end
  endtask

  task automatic stepCycle();
    checkField("Baddr", Baddr, `CPU_RESET_PC + cycle, 1'b0);
    fetched.push_back(BmemRead);
    if (wb.valid === 1'b1) idle = 0;
    else idle++;
    if (cycle < pipeDepth) begin
      // Pipeline still filling
      checkField("wb.valid", wb.valid, 1'b0, 1'b0);
      checkField("MeMemControl", MeMemControl, cpuIsaPkg::MEM_NONE, 1'b0);
    end else begin
      retireInstruction(fetched.pop_front());
      retired++;
    end
  endtask

  initial begin
    valueErrors    = 0;
    protocolErrors = 0;
    done           = 1'b0;
    stalled        = 1'b0;
    cycle          = 0;
    retired        = 0;
    idle           = 0;
    waitCycles     = 0;
    for (int i = 0; i < `CPU_REG_COUNT; i++) begin
      modelRegs[i] = '0;
    end

    @(negedge clk);
    while (rst !== 1'b0 && waitCycles < resetLimit) begin
      @(negedge clk);
      waitCycles++;
    end

    if (rst !== 1'b0) begin
      $display("Reset was never released");
      stalled = 1'b1;
    end else begin
      memCopy = dataImage; // Nothing is stored before the first writeback slot
      while (retired < runLength && idle < idleLimit) begin
        stepCycle();
        @(negedge clk);
        cycle++;
      end
      if (retired < runLength) begin
        $display("No writeback seen for %0d cycles after %0d instructions", idleLimit, retired);
        stalled = 1'b1;
      end else begin
        // Last write has landed by now
        for (int i = 0; i < `CPU_REG_COUNT; i++) begin
          checkField($sformatf("registerValue[%0d]", i), registerValue[i], modelRegs[i], 1'b1);
        end
        done = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/cpu.sv
`default_nettype none
`include "cpu_settings.svh"

module cpu (
  input  logic                                  clk,
  input  logic                                  rst,
  output cpuIsaPkg::word_t                      Baddr,
  output cpuIsaPkg::word_t                      Aaddr,
  output cpuIsaPkg::word_t                      dataWrite,
  output cpuIsaPkg::memControl_t                MeMemControl,
  input  cpuIsaPkg::word_t                      BmemRead,
  input  cpuIsaPkg::word_t                      AmemRead,
  output cpuPipePkg::writeback_t                wb,
  output cpuIsaPkg::word_t [`CPU_REG_COUNT-1:0] registerValue
);

  cpuIsaPkg::word_t     ir;
  logic                 irValid;
  cpuPipePkg::decoded_t dec;
  cpuIsaPkg::word_t     valueS;
  cpuIsaPkg::word_t     valueM;
  cpuIsaPkg::word_t     operandS;
  cpuIsaPkg::word_t     operandM;
  cpuIsaPkg::word_t     aluResult;
  cpuPipePkg::exStage_t exStage;
  cpuPipePkg::meStage_t meStage;

  fetchStage fetch (
    .clk     (clk),
    .rst     (rst),
    .BmemRead(BmemRead),
    .Baddr   (Baddr),
    .ir      (ir),
    .irValid (irValid)
  );

  instructionDecoder decoder (
    .ir     (ir),
    .irValid(irValid),
    .dec    (dec)
  );

  registerFile regFile (
    .clk          (clk),
    .rst          (rst),
    .readS        (dec.rs),
    .readM        (dec.rm),
    .write        (wb),
    .valueS       (valueS),
    .valueM       (valueM),
    .registerValue(registerValue)
  );

  operandBypass bypassS (
    .source   (dec.rs),
    .fileValue(valueS),
    .exStage  (exStage),
    .exResult (aluResult),
    .meWrite  (wb),
    .operand  (operandS)
  );

  operandBypass bypassM (
    .source   (dec.rm),
    .fileValue(valueM),
    .exStage  (exStage),
    .exResult (aluResult),
    .meWrite  (wb),
    .operand  (operandM)
  );

  alu calculator (
    .exStage(exStage),
    .result (aluResult)
  );

  // Decode to execute
  always_ff @(posedge clk) begin
    if (rst) begin
      exStage.valid      <= 1'b0;
      exStage.writes     <= 1'b0;
      exStage.memControl <= cpuIsaPkg::MEM_NONE;
    end else begin
      exStage.valid      <= irValid;
      exStage.opcode     <= dec.opcode;
      exStage.rt         <= dec.rt;
      exStage.writes     <= dec.writes;
      exStage.memControl <= dec.memControl;
      exStage.operandS   <= operandS;
      exStage.operandM   <= operandM;
      exStage.immediate  <= dec.immediate;
    end
  end

  // Execute to memory/writeback
  always_ff @(posedge clk) begin
    if (rst) begin
      meStage.valid      <= 1'b0;
      meStage.writes     <= 1'b0;
      meStage.memControl <= cpuIsaPkg::MEM_NONE;
    end else begin
      meStage.valid      <= exStage.valid;
      meStage.rt         <= exStage.rt;
      meStage.writes     <= exStage.writes;
      meStage.memControl <= exStage.memControl;
      meStage.result     <= aluResult;
      meStage.storeData  <= exStage.operandM; // rm value for ST
    end
  end

  assign Aaddr        = meStage.result;
  assign dataWrite    = meStage.storeData;
  assign MeMemControl = meStage.memControl; // NOPs carry MEM_NONE

  // Port A answers in the same cycle, so loads write back here
  assign wb.valid = meStage.valid && meStage.writes;
  assign wb.rt    = meStage.rt;
  assign wb.value = (meStage.memControl == cpuIsaPkg::MEM_READ) ? AmemRead : meStage.result;

endmodule

`default_nettype wire

// File: rtl/alu.sv
`default_nettype none
`include "cpu_settings.svh"

module alu (
  input  cpuPipePkg::exStage_t exStage,
  output cpuIsaPkg::word_t     result
);

  logic [$clog2(`CPU_WORD_WIDTH)-1:0] shiftAmount;

  assign shiftAmount = exStage.operandM[$clog2(`CPU_WORD_WIDTH)-1:0]; // Low bits of rm

  always_comb begin
    case (exStage.opcode)
      cpuIsaPkg::ADD: begin
        result = exStage.operandS + exStage.operandM;
      end
      cpuIsaPkg::SUB: begin
        result = exStage.operandS - exStage.operandM;
      end
      cpuIsaPkg::AND: begin
        result = exStage.operandS & exStage.operandM;
      end
      cpuIsaPkg::OR: begin
        result = exStage.operandS | exStage.operandM;
      end
      cpuIsaPkg::XOR: begin
        result = exStage.operandS ^ exStage.operandM;
      end
      cpuIsaPkg::SHL: begin
        result = exStage.operandS << shiftAmount;
      end
      cpuIsaPkg::SHR: begin
        result = exStage.operandS >> shiftAmount; // Logical, zero fill
      end
      cpuIsaPkg::LDI: begin
        result = exStage.immediate;
      end
      cpuIsaPkg::LD, cpuIsaPkg::ST: begin
        result = exStage.operandS;  // Data address
      end
      default: begin
        result = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/operandBypass.sv
`default_nettype none

module operandBypass (
  input  cpuIsaPkg::regIndex_t   source,
  input  cpuIsaPkg::word_t       fileValue,
  input  cpuPipePkg::exStage_t   exStage,
  input  cpuIsaPkg::word_t       exResult,
  input  cpuPipePkg::writeback_t meWrite,
  output cpuIsaPkg::word_t       operand
);

  logic exHit;
  logic meHit;

  // Load data does not exist yet in execute, so that stage is skipped
  assign exHit = exStage.valid && exStage.writes && (exStage.rt == source)
                 && (exStage.memControl != cpuIsaPkg::MEM_READ);
  assign meHit = meWrite.valid && (meWrite.rt == source);

  always_comb begin
    if (exHit) begin
      operand = exResult;       // Youngest producer wins
    end else if (meHit) begin
      operand = meWrite.value;
    end else begin
      operand = fileValue;
    end
  end

  // Load followed directly by a reader of its target breaks the program rule
  loadUseGap: assert final (
    exStage.valid !== 1'b1 || exStage.memControl != cpuIsaPkg::MEM_READ
    || exStage.rt != source
  ) else $error("Load result used by the next instruction, r%0d", source);

endmodule

`default_nettype wire

// File: rtl/registerFile.sv
`default_nettype none
`include "cpu_settings.svh"

module registerFile (
  input  logic                                  clk,
  input  logic                                  rst,
  input  cpuIsaPkg::regIndex_t                  readS,
  input  cpuIsaPkg::regIndex_t                  readM,
  input  cpuPipePkg::writeback_t                write,
  output cpuIsaPkg::word_t                      valueS,
  output cpuIsaPkg::word_t                      valueM,
  output cpuIsaPkg::word_t [`CPU_REG_COUNT-1:0] registerValue
);

  cpuIsaPkg::word_t [`CPU_REG_COUNT-1:0] regs;

  // Reads see the old value during a write; the bypass covers that case
  assign valueS = regs[readS];
  assign valueM = regs[readM];

  assign registerValue = regs; // Whole file for inspection

  always_ff @(posedge clk) begin
    if (rst) begin
      regs <= '0;
    end else if (write.valid) begin
      regs[write.rt] <= write.value;
    end
  end

  // An X index would corrupt an unknown register
  writeIndexKnown: assert property (
    @(posedge clk) disable iff (rst) write.valid |-> !$isunknown(write.rt)
  ) else $error("Register write with unknown index");

endmodule

`default_nettype wire

// File: rtl/instructionDecoder.sv
`default_nettype none
`include "cpu_settings.svh"

module instructionDecoder (
  input  cpuIsaPkg::word_t     ir,
  input  logic                 irValid,
  output cpuPipePkg::decoded_t dec
);

  cpuIsaPkg::opcode_t opField;
  cpuIsaPkg::word_t   immExt;

  // Out-of-range codes land on the default branch below
  assign opField = cpuIsaPkg::opcode_t'(ir[cpuIsaPkg::opcodeLsb +: $bits(cpuIsaPkg::opcode_t)]);

  assign immExt = {{(`CPU_WORD_WIDTH - cpuIsaPkg::immWidth){ir[cpuIsaPkg::immWidth-1]}},
                   ir[cpuIsaPkg::immWidth-1:0]};

  always_comb begin
    dec = '0; // NOP, MEM_NONE, no register write
    if (irValid) begin
      // Unread source fields are passed through raw from the word
      dec.rt        = ir[cpuIsaPkg::rtLsb +: $bits(cpuIsaPkg::regIndex_t)];
      dec.rs        = ir[cpuIsaPkg::rsLsb +: $bits(cpuIsaPkg::regIndex_t)];
      dec.rm        = ir[cpuIsaPkg::rmLsb +: $bits(cpuIsaPkg::regIndex_t)];
      dec.immediate = immExt;

      case (opField)
        cpuIsaPkg::ADD, cpuIsaPkg::SUB, cpuIsaPkg::AND, cpuIsaPkg::OR,
        cpuIsaPkg::XOR, cpuIsaPkg::SHL, cpuIsaPkg::SHR, cpuIsaPkg::LDI: begin
          dec.opcode = opField;
          dec.writes = 1'b1;
        end
        cpuIsaPkg::LD: begin
          dec.opcode     = opField;
          dec.writes     = 1'b1;
          dec.memControl = cpuIsaPkg::MEM_READ;
        end
        cpuIsaPkg::ST: begin
          dec.opcode     = opField;
          dec.memControl = cpuIsaPkg::MEM_WRITE; // Stores write no register
        end
        default: begin
          dec.opcode = cpuIsaPkg::NOP;   // NOP and undefined codes
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: rtl/fetchStage.sv
`default_nettype none
`include "cpu_settings.svh"

module fetchStage (
  input  logic             clk,
  input  logic             rst,
  input  cpuIsaPkg::word_t BmemRead,
  output cpuIsaPkg::word_t Baddr,
  output cpuIsaPkg::word_t ir,
  output logic             irValid
);

  cpuIsaPkg::word_t pc;
  cpuIsaPkg::word_t nextPC;

  assign nextPC = pc + 1'b1; // The PC only counts up
  assign Baddr  = pc;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc      <= `CPU_RESET_PC;
      irValid <= 1'b0;
    end else begin
      pc      <= nextPC;
      irValid <= 1'b1;       // Word at the PC is always usable a cycle later
    end
  end

  // Port B answers in the same cycle
  always_ff @(posedge clk) begin
    ir <= BmemRead;
  end

  // An X instruction would turn every decoded control bit unknown
  irKnown: assert property (
    @(posedge clk) disable iff (rst) irValid |-> !$isunknown(ir)
  ) else $error("Fetched instruction is unknown");

endmodule

`default_nettype wire

// File: rtl/cpuPipePkg.sv
`default_nettype none

package cpuPipePkg;

  typedef struct packed {
    cpuIsaPkg::opcode_t     opcode;
    cpuIsaPkg::regIndex_t   rs;
    cpuIsaPkg::regIndex_t   rm;
    cpuIsaPkg::regIndex_t   rt;
    logic                   writes;      // Result goes to rt
    cpuIsaPkg::memControl_t memControl;
    cpuIsaPkg::word_t       immediate;   // Already sign-extended
  } decoded_t;

  // Decode to execute
  typedef struct packed {
    logic                   valid;
    cpuIsaPkg::opcode_t     opcode;
    cpuIsaPkg::regIndex_t   rt;
    logic                   writes;
    cpuIsaPkg::memControl_t memControl;
    cpuIsaPkg::word_t       operandS;
    cpuIsaPkg::word_t       operandM;
    cpuIsaPkg::word_t       immediate;
  } exStage_t;

  // Execute to memory/writeback
  typedef struct packed {
    logic                   valid;
    cpuIsaPkg::regIndex_t   rt;
    logic                   writes;
    cpuIsaPkg::memControl_t memControl;
    cpuIsaPkg::word_t       result;     // Also the data address for LD and ST
    cpuIsaPkg::word_t       storeData;
  } meStage_t;

  typedef struct packed {
    logic                 valid;
    cpuIsaPkg::regIndex_t rt;
    cpuIsaPkg::word_t     value;
  } writeback_t;

endpackage

`default_nettype wire

// File: rtl/cpuIsaPkg.sv
`default_nettype none
`include "cpu_settings.svh"

package cpuIsaPkg;

  typedef logic [`CPU_WORD_WIDTH-1:0] word_t;
  typedef logic [$clog2(`CPU_REG_COUNT)-1:0] regIndex_t;

  // Top nibble of an instruction, codes 4'hB..4'hF are undefined
  typedef enum logic [3:0] {
    NOP = 4'h0,
    ADD = 4'h1,
    SUB = 4'h2,
    AND = 4'h3,
    OR  = 4'h4,
    XOR = 4'h5,
    SHL = 4'h6,  // Shift rs by rm[3:0]
    SHR = 4'h7,
    LDI = 4'h8,  // rt <- sign-extended low byte
    LD  = 4'h9,  // rt <- mem[rs]
    ST  = 4'hA   // mem[rs] <- rm
  } opcode_t;

  typedef enum logic [1:0] {
    MEM_NONE  = 2'b00,
    MEM_READ  = 2'b01,
    MEM_WRITE = 2'b10
  } memControl_t;

  // Instruction layout: opcode | rt | rs | rm
  localparam int unsigned opcodeLsb = 12;
  localparam int unsigned rtLsb     = 8;
  localparam int unsigned rsLsb     = 4;
  localparam int unsigned rmLsb     = 0;
  localparam int unsigned immWidth  = 8;  // LDI immediate overlays rs and rm

endpackage

`default_nettype wire

// File: rtl/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Data and instruction width, fixed by the instruction format
`define CPU_WORD_WIDTH 16

// Architectural registers
`define CPU_REG_COUNT 16

// First fetch address out of reset
`define CPU_RESET_PC 16'd0

`endif
